/* build.f */
+incdir+logic
logic/rv_decode_pkg.sv
logic/op_decoder.sv
logic/format_imm_unit.sv
logic/hazard_unit.sv
logic/issue_register.sv
logic/decode_stage.sv
test/decode_stage_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module decode_stage_tb -o decode_stage_sim || exit 1

result=$(./obj_dir/decode_stage_sim)
echo "$result"
echo "$result" | grep -q "Verification passed" && exit 0 || exit 1

/* test/decode_stage_tb.sv */
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module decode_stage_tb
    import rv_decode_pkg::*;
;

    localparam word_t nop_word = 32'h0000_0013;

    logic      clk;
    logic      reset;
    logic      stall_i;
    word_t     instruction_i;
    word_t     pc_i;
    tag_t      tag_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    reg_addr_t rs1_o;
    reg_addr_t rs2_o;
    reg_addr_t rd_o;
    logic      hazard_o;
    word_t     first_operand_o;
    word_t     second_operand_o;
    word_t     third_operand_o;
    word_t     pc_o;
    word_t     instr_o;
    tag_t      tag_o;
    op_e       operation_o;
    logic      exc_illegal_o;
    logic      exc_misaligned_o;

    int n_checks = 0;
    int n_errors = 0;
    tag_t next_tag = '0;

    // Reference state of the stage
    logic      exp_valid = 1'b0;
    word_t     exp_first;
    word_t     exp_second;
    word_t     exp_third;
    word_t     exp_pc;
    word_t     exp_instr;
    tag_t      exp_tag;
    op_e       exp_op;
    logic      exp_illegal;
    logic      exp_misaligned;
    reg_addr_t ref_lock;
    logic      ref_store;
    reg_addr_t ref_rd;

    // Decode tables indexed by funct3
    op_e branch_ops[8] = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
    op_e load_ops[8]   = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
    op_e store_ops[8]  = '{SB, SH, SW, INVALID, INVALID, INVALID, INVALID, INVALID};
    op_e alu_ops[8]    = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    op_e csr_ops[8]    = '{INVALID, CSRRW, CSRRS, CSRRC, INVALID, CSRRWI, CSRRSI, CSRRCI};

    decode_stage u_dut (
        .clk              (clk),
        .reset            (reset),
        .stall_i          (stall_i),
        .instruction_i    (instruction_i),
        .pc_i             (pc_i),
        .tag_i            (tag_i),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .rs1_o            (rs1_o),
        .rs2_o            (rs2_o),
        .rd_o             (rd_o),
        .hazard_o         (hazard_o),
        .first_operand_o  (first_operand_o),
        .second_operand_o (second_operand_o),
        .third_operand_o  (third_operand_o),
        .pc_o             (pc_o),
        .instr_o          (instr_o),
        .tag_o            (tag_o),
        .operation_o      (operation_o),
        .exc_illegal_o    (exc_illegal_o),
        .exc_misaligned_o (exc_misaligned_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register file and reference functions
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t regfile_value(reg_addr_t r);
        return word_t'(r) * 32'h0101_0101;
    endfunction

    assign rs1_data_i = regfile_value(rs1_o);
    assign rs2_data_i = regfile_value(rs2_o);

    function automatic word_t encode(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd, opcode_t opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic op_e decode_op(word_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        op_e        op;
        f3 = w[14:12];
        f7 = w[31:25];
        op = INVALID;
        case (w[6:0])
            `RV_OPC_LUI:      op = LUI;
            `RV_OPC_AUIPC:    op = ADD;
            `RV_OPC_JAL:      op = JAL;
            `RV_OPC_JALR:     op = (f3 == 3'd0) ? JALR : INVALID;
            `RV_OPC_BRANCH:   op = branch_ops[f3];
            `RV_OPC_LOAD:     op = load_ops[f3];
            `RV_OPC_STORE:    op = store_ops[f3];
            `RV_OPC_OP_IMM: begin
                op = alu_ops[f3];
                if (f3 == 3'd1 && f7 != 7'h00) begin
                    op = INVALID;
                end
                if (f3 == 3'd5) begin
                    op = (f7 == 7'h00) ? SRL : (f7 == 7'h20) ? SRA : INVALID;
                end
            end
            `RV_OPC_OP: begin
                if (f7 == 7'h00) begin
                    op = alu_ops[f3];
                end else if (f7 == 7'h20 && f3 == 3'd0) begin
                    op = SUB;
                end else if (f7 == 7'h20 && f3 == 3'd5) begin
                    op = SRA;
                end
            end
            `RV_OPC_MISC_MEM: op = (f3 == 3'd0) ? NOP : INVALID;
            `RV_OPC_SYSTEM: begin
                if (f3 != 3'd0) begin
                    op = csr_ops[f3];
                end else if (w[19:15] == 5'd0 && w[11:7] == 5'd0) begin
                    case (w[31:20])
                        12'h000: op = ECALL;
                        12'h001: op = EBREAK;
                        12'h102: op = SRET;
                        12'h302: op = MRET;
                        12'h105: op = WFI;
                        default: op = INVALID;
                    endcase
                end
            end
            default: op = INVALID;
        endcase
        return op;
    endfunction

    // Only opcode bits 6:2 pick the format
    function automatic fmt_e classify_format(word_t w);
        case ({w[6:2], 2'b11})
            `RV_OPC_JALR, `RV_OPC_LOAD, `RV_OPC_OP_IMM: return I_TYPE;
            `RV_OPC_STORE:               return S_TYPE;
            `RV_OPC_BRANCH:              return B_TYPE;
            `RV_OPC_LUI, `RV_OPC_AUIPC:  return U_TYPE;
            `RV_OPC_JAL:                 return J_TYPE;
            default:                     return R_TYPE;
        endcase
    endfunction

    function automatic word_t build_imm(word_t w, fmt_e fmt);
        case (fmt)
            I_TYPE:  return {{20{w[31]}}, w[31:20]};
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'h000};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] want);
        n_checks++;
        assert (got === want) else begin
            n_errors++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, want);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checker, sampled on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        fmt_e      fmt;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        logic      use1;
        logic      use2;
        logic      is_load;
        logic      haz;
        if (exp_valid) begin
            compare("operation_o", 32'(operation_o), 32'(exp_op));
            compare("exc_illegal_o", 32'(exc_illegal_o), 32'(exp_illegal));
            compare("exc_misaligned_o", 32'(exc_misaligned_o), 32'(exp_misaligned));
            compare("first_operand_o", first_operand_o, exp_first);
            compare("second_operand_o", second_operand_o, exp_second);
            compare("third_operand_o", third_operand_o, exp_third);
            compare("pc_o", pc_o, exp_pc);
            compare("instr_o", instr_o, exp_instr);
            compare("tag_o", 32'(tag_o), 32'(exp_tag));
            compare("rd_o", 32'(rd_o), 32'(ref_rd));
        end
        if (reset) begin
            ref_lock       = '0;
            ref_store      = 1'b0;
            ref_rd         = '0;
            exp_first      = '0;
            exp_second     = '0;
            exp_third      = '0;
            exp_pc         = '0;
            exp_instr      = '0;
            exp_tag        = '0;
            exp_op         = NOP;
            exp_illegal    = 1'b0;
            exp_misaligned = 1'b0;
            exp_valid      = 1'b1;
        end else begin
            fmt     = classify_format(instruction_i);
            rs1     = instruction_i[19:15];
            rs2     = instruction_i[24:20];
            use1    = (fmt != U_TYPE) && (fmt != J_TYPE);
            use2    = (fmt == R_TYPE) || (fmt == S_TYPE) || (fmt == B_TYPE);
            is_load = ({instruction_i[6:2], 2'b11} == `RV_OPC_LOAD);
            haz = (use1 && rs1 != '0 && rs1 == ref_lock) ||
                  (use2 && rs2 != '0 && rs2 == ref_lock) ||
                  (ref_store && is_load);
            compare("rs1_o", 32'(rs1_o), 32'(rs1));
            compare("rs2_o", 32'(rs2_o), 32'(rs2));
            compare("hazard_o", 32'(hazard_o), 32'(haz));
            if (haz) begin
                exp_first      = '0;
                exp_second     = '0;
                exp_third      = '0;
                exp_pc         = '0;
                exp_instr      = '0;
                exp_tag        = tag_i;
                exp_op         = NOP;
                exp_illegal    = 1'b0;
                exp_misaligned = 1'b0;
            end else if (!stall_i) begin
                imm       = build_imm(instruction_i, fmt);
                exp_first = (fmt == U_TYPE || fmt == J_TYPE) ? pc_i : regfile_value(rs1);
                case (fmt)
                    R_TYPE, B_TYPE: begin
                        exp_second = regfile_value(rs2);
                        exp_third  = imm;
                    end
                    S_TYPE: begin
                        exp_second = imm;
                        exp_third  = regfile_value(rs2);
                    end
                    default: begin
                        exp_second = imm;
                        exp_third  = imm;
                    end
                endcase
                exp_pc         = pc_i;
                exp_instr      = instruction_i;
                exp_tag        = tag_i;
                exp_op         = decode_op(instruction_i);
                exp_illegal    = (exp_op == INVALID);
                exp_misaligned = (pc_i[1:0] != 2'b00);
            end
            // Lock queue moves only when not stalled
            if (!stall_i) begin
                ref_rd    = ref_lock;
                ref_lock  = haz ? '0 : instruction_i[11:7];
                ref_store = !haz && ({instruction_i[6:2], 2'b11} == `RV_OPC_STORE);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // One instruction, held through any hazard until it replays
    task automatic issue(input word_t instr, input word_t pc, input logic stall,
                         output logic haz);
        int waited;
        @(posedge clk);
        instruction_i <= instr;
        pc_i          <= pc;
        tag_i         <= next_tag;
        stall_i       <= stall;
        next_tag = next_tag + 3'd1;
        @(negedge clk);
        haz    = hazard_o;
        waited = 0;
        while (hazard_o) begin
            if (waited == 16) begin
                $display("Timeout: hazard_o stayed high for 16 cycles");
                $display("Verification failed");
                $finish;
            end else begin
                waited++;
                @(posedge clk);
                stall_i <= 1'b0;
                @(negedge clk);
            end
        end
    endtask

    task automatic random_instr(output word_t w);
        word_t   r;
        opcode_t opc;
        w = $urandom;
        r = $urandom;
        case (r[3:0])
            4'd0:    opc = `RV_OPC_LUI;
            4'd1:    opc = `RV_OPC_AUIPC;
            4'd2:    opc = `RV_OPC_JAL;
            4'd3:    opc = `RV_OPC_JALR;
            4'd4:    opc = `RV_OPC_BRANCH;
            4'd5:    opc = `RV_OPC_LOAD;
            4'd6:    opc = `RV_OPC_STORE;
            4'd7:    opc = `RV_OPC_MISC_MEM;
            4'd8,
            4'd9:    opc = `RV_OPC_SYSTEM;
            4'd10:   opc = w[6:0];
            default: opc = r[4] ? `RV_OPC_OP : `RV_OPC_OP_IMM;
        endcase
        w[6:0] = opc;
        // Bias funct7 toward legal values
        if ((opc == `RV_OPC_OP || opc == `RV_OPC_OP_IMM) && r[6:5] != 2'd3) begin
            w[31:25] = r[6] ? `RV_F7_ALT : `RV_F7_BASE;
        end
        if (opc == `RV_OPC_SYSTEM && r[7]) begin
            w[14:12] = 3'd0;
            w[19:15] = 5'd0;
            w[11:7]  = 5'd0;
            case (r[10:8])
                3'd0:    w[31:20] = `RV_F12_ECALL;
                3'd1:    w[31:20] = `RV_F12_EBREAK;
                3'd2:    w[31:20] = `RV_F12_SRET;
                3'd3:    w[31:20] = `RV_F12_MRET;
                3'd4:    w[31:20] = `RV_F12_WFI;
                default: w[31:20] = r[31:20];
            endcase
        end
    endtask

    initial begin
        word_t instr;
        word_t pc;
        word_t r;
        logic  haz;
        void'($urandom(32'h4462_b33d));
        reset         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = nop_word;
        pc_i          = '0;
        tag_i         = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Read after write on rs1, then on rs2, then on x0
        issue(encode(7'h00, 5'd1, 5'd0, 3'd0, 5'd5, `RV_OPC_OP_IMM), 32'h100, 1'b0, haz);
        issue(encode(7'h00, 5'd0, 5'd5, 3'd0, 5'd6, `RV_OPC_OP), 32'h104, 1'b0, haz);
        compare("hazard_o on rs1 dependency", 32'(haz), 32'd1);
        issue(encode(7'h00, 5'd2, 5'd0, 3'd0, 5'd7, `RV_OPC_OP_IMM), 32'h108, 1'b0, haz);
        issue(encode(7'h20, 5'd7, 5'd0, 3'd0, 5'd8, `RV_OPC_OP), 32'h10c, 1'b0, haz);
        compare("hazard_o on rs2 dependency", 32'(haz), 32'd1);
        issue(encode(7'h00, 5'd5, 5'd0, 3'd0, 5'd0, `RV_OPC_OP_IMM), 32'h110, 1'b0, haz);
        issue(encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd9, `RV_OPC_OP), 32'h114, 1'b0, haz);
        compare("hazard_o after write to x0", 32'(haz), 32'd0);

        // Store then load, store then ALU
        issue(encode(7'h00, 5'd2, 5'd1, 3'd2, 5'd0, `RV_OPC_STORE), 32'h118, 1'b0, haz);
        issue(encode(7'h00, 5'd0, 5'd4, 3'd2, 5'd3, `RV_OPC_LOAD), 32'h11c, 1'b0, haz);
        compare("hazard_o on load after store", 32'(haz), 32'd1);
        issue(encode(7'h00, 5'd2, 5'd1, 3'd2, 5'd0, `RV_OPC_STORE), 32'h120, 1'b0, haz);
        issue(encode(7'h00, 5'd13, 5'd12, 3'd0, 5'd11, `RV_OPC_OP), 32'h124, 1'b0, haz);
        compare("hazard_o on ALU after store", 32'(haz), 32'd0);

        // Stall burst and a misaligned PC
        issue(encode(7'h00, 5'd3, 5'd0, 3'd0, 5'd12, `RV_OPC_OP_IMM), 32'h128, 1'b0, haz);
        repeat (3) begin
            issue(encode(7'h7f, 5'd31, 5'd0, 3'd4, 5'd13, `RV_OPC_OP_IMM), 32'h12c, 1'b1,
                  haz);
        end
        issue(encode(7'h00, 5'd1, 5'd0, 3'd0, 5'd14, `RV_OPC_OP_IMM), 32'h1002, 1'b0, haz);
        issue(encode(7'h12, 5'd13, 5'd5, 3'd4, 5'd15, `RV_OPC_LUI), 32'h1009, 1'b0, haz);

        // Random mix of all opcode classes
        for (int i = 0; i < 400; i++) begin
            random_instr(instr);
            r  = $urandom;
            pc = r;
            if (r[5:3] != 3'd0) begin
                pc[1:0] = 2'b00;
            end
            issue(instr, pc, r[8:6] == 3'd0, haz);
        end
        repeat (3) issue(nop_word, 32'h0, 1'b0, haz);

        $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog for the whole run
    initial begin
        #200000;
        $display("Timeout: simulation did not finish within 200 us");
        $display("Verification failed");
        $finish;
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
    import rv_decode_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall_i,
    input  word_t     instruction_i,
    input  word_t     pc_i,
    input  tag_t      tag_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output reg_addr_t rd_o,
    output logic      hazard_o,
    output word_t     first_operand_o,
    output word_t     second_operand_o,
    output word_t     third_operand_o,
    output word_t     pc_o,
    output word_t     instr_o,
    output tag_t      tag_o,
    output op_e       operation_o,
    output logic      exc_illegal_o,
    output logic      exc_misaligned_o
);

    // Instruction after replay selection
    word_t eff_instr;
    fmt_e  fmt;
    word_t imm;
    op_e   op;
    logic  illegal;

    hazard_unit u_hazard (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .fmt_i         (fmt),
        .instr_o       (eff_instr),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .rd_o          (rd_o),
        .hazard_o      (hazard_o)
    );

    op_decoder u_op_dec (
        .instr_i   (eff_instr),
        .op_o      (op),
        .illegal_o (illegal)
    );

    format_imm_unit u_fmt_imm (
        .instr_i (eff_instr),
        .fmt_o   (fmt),
        .imm_o   (imm)
    );

    issue_register u_issue (
        .clk              (clk),
        .reset            (reset),
        .stall_i          (stall_i),
        .hazard_i         (hazard_o),
        .instr_i          (eff_instr),
        .pc_i             (pc_i),
        .tag_i            (tag_i),
        .op_i             (op),
        .illegal_i        (illegal),
        .fmt_i            (fmt),
        .imm_i            (imm),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .first_operand_o  (first_operand_o),
        .second_operand_o (second_operand_o),
        .third_operand_o  (third_operand_o),
        .pc_o             (pc_o),
        .instr_o          (instr_o),
        .tag_o            (tag_o),
        .operation_o      (operation_o),
        .exc_illegal_o    (exc_illegal_o),
        .exc_misaligned_o (exc_misaligned_o)
    );

endmodule

/* logic/issue_register.sv */
`timescale 1ns/100ps

module issue_register
    import rv_decode_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall_i,
    input  logic  hazard_i,
    input  word_t instr_i,
    input  word_t pc_i,
    input  tag_t  tag_i,
    input  op_e   op_i,
    input  logic  illegal_i,
    input  fmt_e  fmt_i,
    input  word_t imm_i,
    input  word_t rs1_data_i,
    input  word_t rs2_data_i,
    output word_t first_operand_o,
    output word_t second_operand_o,
    output word_t third_operand_o,
    output word_t pc_o,
    output word_t instr_o,
    output tag_t  tag_o,
    output op_e   operation_o,
    output logic  exc_illegal_o,
    output logic  exc_misaligned_o
);

    word_t first_operand;
    word_t second_operand;
    word_t third_operand;
    logic  misaligned;

    ////////////////////////////////////////////////////////////////////////////
    // Operand select by format
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (fmt_i)
            U_TYPE, J_TYPE: begin
                first_operand  = pc_i;
                second_operand = imm_i;
                third_operand  = imm_i;
            end
            R_TYPE, B_TYPE: begin
                first_operand  = rs1_data_i;
                second_operand = rs2_data_i;
                third_operand  = imm_i;
            end
            // Store data rides in the third slot
            S_TYPE: begin
                first_operand  = rs1_data_i;
                second_operand = imm_i;
                third_operand  = rs2_data_i;
            end
            default: begin
                first_operand  = rs1_data_i;
                second_operand = imm_i;
                third_operand  = imm_i;
            end
        endcase
    end

    assign misaligned = (pc_i[1:0] != 2'b00);

    ////////////////////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            first_operand_o  <= '0;
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            instr_o          <= '0;
            tag_o            <= '0;
            operation_o      <= NOP;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (hazard_i) begin
            // Bubble goes out even while stalled, keeping the tag
            first_operand_o  <= '0;
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            instr_o          <= '0;
            tag_o            <= tag_i;
            operation_o      <= NOP;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (!stall_i) begin
            first_operand_o  <= first_operand;
            second_operand_o <= second_operand;
            third_operand_o  <= third_operand;
            pc_o             <= pc_i;
            instr_o          <= instr_i;
            tag_o            <= tag_i;
            operation_o      <= op_i;
            exc_illegal_o    <= illegal_i;
            exc_misaligned_o <= misaligned;
        end
    end

endmodule

/* logic/hazard_unit.sv */
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module hazard_unit
    import rv_decode_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall_i,
    input  word_t     instruction_i,
    input  fmt_e      fmt_i,
    output word_t     instr_o,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output reg_addr_t rd_o,
    output logic      hazard_o
);

    word_t     last_instr;
    logic      last_hazard;
    opcode_t   opc_class;
    reg_addr_t target_reg;
    reg_addr_t locked_reg;
    logic      is_store;
    logic      is_load;
    logic      locked_store;
    logic      use_rs1;
    logic      use_rs2;

    ////////////////////////////////////////////////////////////////////////////
    // Replay of the instruction that was bubbled
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        last_instr <= instr_o;
        if (reset) begin
            last_hazard <= 1'b0;
        end else begin
            last_hazard <= hazard_o;
        end
    end

    assign instr_o = last_hazard ? last_instr : instruction_i;

    assign rs1_o     = instr_o[19:15];
    assign rs2_o     = instr_o[24:20];
    assign opc_class = {instr_o[6:2], 2'b11};
    assign is_load   = (opc_class == `RV_OPC_LOAD);

    // A bubble locks nothing
    assign target_reg = hazard_o ? '0 : instr_o[11:7];
    assign is_store   = !hazard_o && (opc_class == `RV_OPC_STORE);

    ////////////////////////////////////////////////////////////////////////////
    // Register lock queue
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_o         <= '0;
            locked_reg   <= '0;
            locked_store <= 1'b0;
        end else if (!stall_i) begin
            rd_o         <= locked_reg;
            locked_reg   <= target_reg;
            locked_store <= is_store;
        end
    end

    // Source usage per format
    assign use_rs1 = (fmt_i == R_TYPE) || (fmt_i == I_TYPE) ||
                     (fmt_i == S_TYPE) || (fmt_i == B_TYPE);
    assign use_rs2 = (fmt_i == R_TYPE) || (fmt_i == S_TYPE) || (fmt_i == B_TYPE);

    assign hazard_o = (use_rs1 && rs1_o != '0 && rs1_o == locked_reg) ||
                      (use_rs2 && rs2_o != '0 && rs2_o == locked_reg) ||
                      (locked_store && is_load);

endmodule

/* logic/format_imm_unit.sv */
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module format_imm_unit
    import rv_decode_pkg::*;
(
    input  word_t instr_i,
    output fmt_e  fmt_o,
    output word_t imm_o
);

    opcode_t opc_class;
    word_t   imm_i_type;
    word_t   imm_s_type;
    word_t   imm_b_type;
    word_t   imm_u_type;
    word_t   imm_j_type;

    // Bits 1:0 are always 11 in RV32I, so only bits 6:2 decide
    assign opc_class = {instr_i[6:2], 2'b11};

    always_comb begin
        case (opc_class)
            `RV_OPC_JALR,
            `RV_OPC_LOAD,
            `RV_OPC_OP_IMM: fmt_o = I_TYPE;
            `RV_OPC_STORE:  fmt_o = S_TYPE;
            `RV_OPC_BRANCH: fmt_o = B_TYPE;
            `RV_OPC_LUI,
            `RV_OPC_AUIPC:  fmt_o = U_TYPE;
            `RV_OPC_JAL:    fmt_o = J_TYPE;
            default:        fmt_o = R_TYPE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Immediate assembly, sign bit is always instr[31]
    ////////////////////////////////////////////////////////////////////////////

    assign imm_i_type = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s_type = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'h000};
    assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    always_comb begin
        case (fmt_o)
            I_TYPE:  imm_o = imm_i_type;
            S_TYPE:  imm_o = imm_s_type;
            B_TYPE:  imm_o = imm_b_type;
            U_TYPE:  imm_o = imm_u_type;
            J_TYPE:  imm_o = imm_j_type;
            // R-type carries no immediate
            default: imm_o = '0;
        endcase
    end

endmodule

/* logic/op_decoder.sv */
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module op_decoder
    import rv_decode_pkg::*;
(
    input  word_t instr_i,
    output op_e   op_o,
    output logic  illegal_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       sys_regs_zero;

    op_e dec_branch;
    op_e dec_load;
    op_e dec_store;
    op_e dec_op_imm;
    op_e dec_op;
    op_e dec_misc_mem;
    op_e dec_system;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Privileged ops need rs1 and rd cleared
    assign sys_regs_zero = (instr_i[19:15] == '0) && (instr_i[11:7] == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Per-class tables
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  dec_branch = BEQ;
            3'b001:  dec_branch = BNE;
            3'b100:  dec_branch = BLT;
            3'b101:  dec_branch = BGE;
            3'b110:  dec_branch = BLTU;
            3'b111:  dec_branch = BGEU;
            default: dec_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_load = LB;
            3'b001:  dec_load = LH;
            3'b010:  dec_load = LW;
            3'b100:  dec_load = LBU;
            3'b101:  dec_load = LHU;
            default: dec_load = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_store = SB;
            3'b001:  dec_store = SH;
            3'b010:  dec_store = SW;
            default: dec_store = INVALID;
        endcase
    end

    // Only the shifts look at funct7
    always_comb begin
        case (funct3)
            3'b000:  dec_op_imm = ADD;
            3'b001:  dec_op_imm = (funct7 == `RV_F7_BASE) ? SLL : INVALID;
            3'b010:  dec_op_imm = SLT;
            3'b011:  dec_op_imm = SLTU;
            3'b100:  dec_op_imm = XOR;
            3'b101:  dec_op_imm = (funct7 == `RV_F7_BASE) ? SRL :
                                  (funct7 == `RV_F7_ALT)  ? SRA : INVALID;
            3'b110:  dec_op_imm = OR;
            default: dec_op_imm = AND;
        endcase
    end

    always_comb begin
        case ({funct7, funct3})
            {`RV_F7_BASE, 3'b000}: dec_op = ADD;
            {`RV_F7_ALT,  3'b000}: dec_op = SUB;
            {`RV_F7_BASE, 3'b001}: dec_op = SLL;
            {`RV_F7_BASE, 3'b010}: dec_op = SLT;
            {`RV_F7_BASE, 3'b011}: dec_op = SLTU;
            {`RV_F7_BASE, 3'b100}: dec_op = XOR;
            {`RV_F7_BASE, 3'b101}: dec_op = SRL;
            {`RV_F7_ALT,  3'b101}: dec_op = SRA;
            {`RV_F7_BASE, 3'b110}: dec_op = OR;
            {`RV_F7_BASE, 3'b111}: dec_op = AND;
            default:               dec_op = INVALID;
        endcase
    end

    // FENCE retires as a NOP in this in-order core
    assign dec_misc_mem = (funct3 == 3'b000) ? NOP : INVALID;

    always_comb begin
        dec_system = INVALID;
        case (funct3)
            3'b000: begin
                if (sys_regs_zero) begin
                    case (instr_i[31:20])
                        `RV_F12_ECALL:  dec_system = ECALL;
                        `RV_F12_EBREAK: dec_system = EBREAK;
                        `RV_F12_SRET:   dec_system = SRET;
                        `RV_F12_MRET:   dec_system = MRET;
                        `RV_F12_WFI:    dec_system = WFI;
                        default:        dec_system = INVALID;
                    endcase
                end
            end
            3'b001:  dec_system = CSRRW;
            3'b010:  dec_system = CSRRS;
            3'b011:  dec_system = CSRRC;
            3'b101:  dec_system = CSRRWI;
            3'b110:  dec_system = CSRRSI;
            3'b111:  dec_system = CSRRCI;
            default: dec_system = INVALID;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Opcode select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            `RV_OPC_LUI:      op_o = LUI;
            `RV_OPC_AUIPC:    op_o = ADD;
            `RV_OPC_JAL:      op_o = JAL;
            `RV_OPC_JALR:     op_o = (funct3 == 3'b000) ? JALR : INVALID;
            `RV_OPC_BRANCH:   op_o = dec_branch;
            `RV_OPC_LOAD:     op_o = dec_load;
            `RV_OPC_STORE:    op_o = dec_store;
            `RV_OPC_OP_IMM:   op_o = dec_op_imm;
            `RV_OPC_OP:       op_o = dec_op;
            `RV_OPC_MISC_MEM: op_o = dec_misc_mem;
            `RV_OPC_SYSTEM:   op_o = dec_system;
            default:          op_o = INVALID;
        endcase
    end

    assign illegal_o = (op_o == INVALID);

endmodule

/* logic/rv_decode_pkg.sv */
`include "rv_decode_macros.svh"

package rv_decode_pkg;

    // Vector types with a meaning of their own
    typedef logic [`RV_XLEN-1:0]       word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`RV_TAG_W-1:0]      tag_t;
    typedef logic [`RV_OPC_W-1:0]      opcode_t;

    // Operation handed to the execute stage
    typedef enum logic [5:0] {
        NOP,
        LUI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        ECALL,
        EBREAK,
        SRET,
        MRET,
        WFI,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        INVALID
    } op_e;

    // Encoding formats of the base ISA
    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } fmt_e;

endpackage

/* logic/rv_decode_macros.svh */
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// Datapath and field widths
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_TAG_W       3
`define RV_OPC_W       7

// RV32I base opcodes
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_AUIPC    7'b0010111
`define RV_OPC_JAL      7'b1101111
`define RV_OPC_JALR     7'b1100111
`define RV_OPC_BRANCH   7'b1100011
`define RV_OPC_LOAD     7'b0000011
`define RV_OPC_STORE    7'b0100011
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_OP       7'b0110011
`define RV_OPC_MISC_MEM 7'b0001111
`define RV_OPC_SYSTEM   7'b1110011

// funct7 of OP and of the immediate shifts
`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000

// funct12 of the privileged SYSTEM instructions
`define RV_F12_ECALL  12'h000
`define RV_F12_EBREAK 12'h001
`define RV_F12_SRET   12'h102
`define RV_F12_MRET   12'h302
`define RV_F12_WFI    12'h105

`endif
